// ==== files.f ====
common/piece_pkg.sv
common/board_pkg.sv
hdl/cursor_ctrl.sv
game/move_checker.sv
game/move_sequencer.sv
game/board_store.sv
hdl/chess_game.sv
testbench/chess_game_assert.sv
testbench/chess_game_tb.sv

// ==== Bender.yml ====
package:
  name: chess_game

sources:
  - common/piece_pkg.sv
  - common/board_pkg.sv
  - hdl/cursor_ctrl.sv
  - game/move_checker.sv
  - game/move_sequencer.sv
  - game/board_store.sv
  - hdl/chess_game.sv
  - target: simulation
    files:
      - testbench/chess_game_assert.sv
      - testbench/chess_game_tb.sv

// ==== testbench/chess_game_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module chess_game_tb;

    localparam board_pkg::btn_t BTN_LEFT   = 5'b10000;
    localparam board_pkg::btn_t BTN_RIGHT  = 5'b01000;
    localparam board_pkg::btn_t BTN_UP     = 5'b00100;
    localparam board_pkg::btn_t BTN_DOWN   = 5'b00010;
    localparam board_pkg::btn_t BTN_CENTER = 5'b00001;
    localparam piece_pkg::square_t EMPTY   = '{color: piece_pkg::COLOR_WHITE,
                                               kind: piece_pkg::PIECE_NONE};

    logic               CLK;
    logic               RESET;
    board_pkg::btn_t    buttons;
    board_pkg::board_t  board;
    board_pkg::coord_t  cursor;
    board_pkg::coord_t  selected;
    logic               hilite;
    piece_pkg::color_t  side_to_move;

    piece_pkg::square_t model [64]; // expected board, row*8 + col
    int                 exp_row;
    int                 exp_col;
    int                 errors = 0;
    integer             seed = 24;

    chess_game i_chess_game (
        .CLK          (CLK),
        .RESET        (RESET),
        .buttons      (buttons),
        .board        (board),
        .cursor       (cursor),
        .selected     (selected),
        .hilite       (hilite),
        .side_to_move (side_to_move)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    function automatic piece_pkg::piece_kind_t back_kind(input int col);
        case (col)
            0, 7:    return piece_pkg::PIECE_ROOK;
            1, 6:    return piece_pkg::PIECE_KNIGHT;
            2, 5:    return piece_pkg::PIECE_BISHOP;
            3:       return piece_pkg::PIECE_QUEEN;
            default: return piece_pkg::PIECE_KING;
        endcase
    endfunction

    task automatic init_model();
        for (int i = 0; i < 64; i++) begin
            model[i] = EMPTY;
        end
        for (int c = 0; c < 8; c++) begin
            model[c]      = '{color: piece_pkg::COLOR_BLACK, kind: back_kind(c)};
            model[8 + c]  = '{color: piece_pkg::COLOR_BLACK, kind: piece_pkg::PIECE_PAWN};
            model[48 + c] = '{color: piece_pkg::COLOR_WHITE, kind: piece_pkg::PIECE_PAWN};
            model[56 + c] = '{color: piece_pkg::COLOR_WHITE, kind: back_kind(c)};
        end
    endtask

    task automatic check_board();
        for (int i = 0; i < 64; i++) begin
            check($sformatf("board[%0d]", i), board[i], model[i]);
        end
    endtask

    // one-cycle pulse, then a few random idle cycles
    task automatic press(input board_pkg::btn_t b);
        int idle;
        @(negedge CLK);
        buttons = b;
        @(negedge CLK);
        buttons = '0;
        if (b.left) begin
            if (exp_col > 0) exp_col--;
        end else if (b.right) begin
            if (exp_col < 7) exp_col++;
        end else if (b.up) begin
            if (exp_row > 0) exp_row--;
        end else if (b.down) begin
            if (exp_row < 7) exp_row++;
        end
        check("cursor.row", cursor.row, exp_row);
        check("cursor.col", cursor.col, exp_col);
        idle = $unsigned($random(seed)) % 4;
        repeat (idle) @(negedge CLK);
    endtask

    task automatic goto_square(input int row, input int col);
        int steps;
        steps = 0;
        while ((exp_row != row || exp_col != col) && steps < 16) begin
            if (exp_col > col)      press(BTN_LEFT);
            else if (exp_col < col) press(BTN_RIGHT);
            else if (exp_row > row) press(BTN_UP);
            else                    press(BTN_DOWN);
            steps++;
        end
        if (exp_row != row || exp_col != col) begin
            errors++;
            $display("cursor never reached square row %0d col %0d", row, col);
        end
    endtask

    // select origin, press on target, expect move or no change
    task automatic try_move(input int o_row, input int o_col, input int t_row,
                            input int t_col, input bit expect_ok);
        piece_pkg::color_t side_before;
        int                cycles;
        goto_square(o_row, o_col);
        press(BTN_CENTER);
        check("hilite", hilite, 1'b1);
        check("selected.row", selected.row, o_row);
        check("selected.col", selected.col, o_col);
        goto_square(t_row, t_col);
        side_before = side_to_move;
        press(BTN_CENTER);
        if (expect_ok) begin
            cycles = 0;
            while (side_to_move == side_before && cycles < 20) begin
                @(negedge CLK);
                cycles++;
            end
            if (side_to_move == side_before) begin
                errors++;
                $display("side to move never changed after a legal move");
            end
            model[t_row*8 + t_col] = model[o_row*8 + o_col];
            model[o_row*8 + o_col] = EMPTY;
            check("hilite", hilite, 1'b0);
        end else begin
            repeat (4) @(negedge CLK);
            check("side_to_move", side_to_move, side_before);
            check("hilite", hilite, 1'b1);
        end
        check_board();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests

    task automatic test_reset();
        check_board();
        check("cursor.row", cursor.row, 6);
        check("cursor.col", cursor.col, 4);
        check("selected.row", selected.row, 6);
        check("selected.col", selected.col, 4);
        check("hilite", hilite, 1'b0);
        check("side_to_move", side_to_move, piece_pkg::COLOR_WHITE);
    endtask

    task automatic test_cursor();
        repeat (6) press(BTN_LEFT);  // clamps at the a-file
        repeat (8) press(BTN_UP);
        repeat (9) press(BTN_RIGHT);
        repeat (9) press(BTN_DOWN);
    endtask

    task automatic test_selection();
        goto_square(4, 4); // empty e4
        press(BTN_CENTER);
        check("hilite", hilite, 1'b0);
        goto_square(1, 3); // black pawn
        press(BTN_CENTER);
        check("hilite", hilite, 1'b0);
        goto_square(6, 5); // white pawn f2
        press(BTN_CENTER);
        check("hilite", hilite, 1'b1);
        check("selected.row", selected.row, 6);
        check("selected.col", selected.col, 5);
        goto_square(6, 3); // re-select d2
        press(BTN_CENTER);
        check("hilite", hilite, 1'b1);
        check("selected.row", selected.row, 6);
        check("selected.col", selected.col, 3);
    endtask

    task automatic test_pawn_moves();
        try_move(6, 4, 4, 4, 1'b1); // e2-e4
        try_move(1, 3, 3, 3, 1'b1); // d7-d5
        try_move(6, 2, 3, 2, 1'b0); // c2-c5 is three squares
    endtask

    task automatic test_pieces_capture();
        try_move(7, 6, 5, 5, 1'b1); // Ng1-f3
        try_move(0, 2, 2, 2, 1'b0); // bishop straight down the file
        try_move(1, 4, 3, 4, 1'b1); // e7-e5
        try_move(4, 4, 3, 4, 1'b0); // e4 blocked by e5
        try_move(4, 4, 3, 3, 1'b1); // exd5
    endtask

    initial begin
        RESET   = 1'b1;
        buttons = '0;
        exp_row = 6;
        exp_col = 4;
        init_model();
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        test_reset();
        test_cursor();
        test_selection();
        test_pawn_moves();
        test_pieces_capture();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/chess_game_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module chess_game_assert (
    input wire       CLK,
    input wire       RESET,
    input wire       wr_en,
    input wire [1:0] seq_state,
    input wire       hilite,
    input wire       side_to_move
);

    localparam logic [1:0] ST_SELECT = 2'd0;
    localparam logic [1:0] ST_ERASE  = 2'd3;

    ////////////////////////////////////////////////////////////////////////////
    // sequencer properties

    // target write, then origin erase, nothing more
    assert property (@(posedge CLK) disable iff (RESET)
        wr_en && $past(wr_en) |=> !wr_en)
        else $error("board write enable high for more than two cycles");

    assert property (@(posedge CLK) disable iff (RESET)
        $changed(side_to_move) |-> $past(wr_en && seq_state == ST_ERASE))
        else $error("side to move changed without a preceding erase write");

    assert property (@(posedge CLK) disable iff (RESET)
        seq_state == ST_SELECT |-> !hilite)
        else $error("hilite high while the sequencer waits for a selection");

endmodule

bind chess_game chess_game_assert i_chess_game_assert (
    .CLK          (CLK),
    .RESET        (RESET),
    .wr_en        (wr.en),
    .seq_state    (i_move_sequencer.state),
    .hilite       (hilite),
    .side_to_move (side_to_move)
);

`default_nettype wire

// ==== hdl/chess_game.sv ====
`timescale 1ns/10ps
`default_nettype none

module chess_game (
    input  wire                  CLK,
    input  wire                  RESET,
    input  wire board_pkg::btn_t buttons,
    output board_pkg::board_t    board,
    output board_pkg::coord_t    cursor,
    output board_pkg::coord_t    selected,
    output logic                 hilite,
    output piece_pkg::color_t    side_to_move
);

    logic                 legal;
    board_pkg::board_wr_t wr;

    cursor_ctrl i_cursor_ctrl (
        .CLK     (CLK),
        .RESET   (RESET),
        .buttons (buttons),
        .cursor  (cursor)
    );

    // judged against the board as it stands now
    move_checker i_move_checker (
        .board        (board),
        .selected     (selected),
        .cursor       (cursor),
        .side_to_move (side_to_move),
        .legal        (legal)
    );

    move_sequencer i_move_sequencer (
        .CLK          (CLK),
        .RESET        (RESET),
        .center       (buttons.center),
        .cursor       (cursor),
        .board        (board),
        .legal        (legal),
        .selected     (selected),
        .hilite       (hilite),
        .side_to_move (side_to_move),
        .wr           (wr)
    );

    board_store i_board_store (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .board (board)
    );

endmodule

`default_nettype wire

// ==== game/board_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module board_store (
    input  wire                       CLK,
    input  wire                       RESET,
    input  wire board_pkg::board_wr_t wr,
    output board_pkg::board_t         board
);

    logic [5:0] wr_index;

    assign wr_index = {wr.addr.row, wr.addr.col}; // row*8 + col

    ////////////////////////////////////////////////////////////////////////////
    // square register, one write per cycle

    always_ff @(posedge CLK or posedge RESET) begin
        if (RESET) begin
            board <= board_pkg::START_POSITION;
        end else if (wr.en) begin
            board[wr_index] <= wr.value;
        end
    end

endmodule

`default_nettype wire

// ==== game/move_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module move_sequencer (
    input  wire                     CLK,
    input  wire                     RESET,
    input  wire                     center,
    input  wire board_pkg::coord_t  cursor,
    input  wire board_pkg::board_t  board,
    input  wire                     legal,
    output board_pkg::coord_t       selected,
    output logic                    hilite,
    output piece_pkg::color_t       side_to_move,
    output board_pkg::board_wr_t    wr
);

    typedef enum logic [1:0] {
        ST_SELECT = 2'd0,
        ST_MOVE   = 2'd1,
        ST_WRITE  = 2'd2,
        ST_ERASE  = 2'd3
    } state_t;

    state_t             state;
    piece_pkg::square_t cur_sq;
    piece_pkg::square_t sel_sq;
    logic               own_piece;
    logic               do_move;
    logic               wr_en;
    board_pkg::coord_t  wr_addr;
    piece_pkg::square_t wr_value;

    assign cur_sq = board[{cursor.row, cursor.col}];
    assign sel_sq = board[{selected.row, selected.col}];

    assign own_piece = (cur_sq.kind != piece_pkg::PIECE_NONE)
                    && (cur_sq.color == side_to_move);
    assign do_move   = (state == ST_MOVE) && center && !own_piece && legal;

    ////////////////////////////////////////////////////////////////////////////
    // control FSM

    always_ff @(posedge CLK or posedge RESET) begin
        if (RESET) begin
            state        <= ST_SELECT;
            selected     <= board_pkg::CURSOR_START;
            hilite       <= 1'b0;
            side_to_move <= piece_pkg::COLOR_WHITE;
            wr_en        <= 1'b0;
        end else begin
            case (state)
                ST_SELECT: begin
                    if (center && own_piece) begin
                        selected <= cursor;
                        hilite   <= 1'b1;
                        state    <= ST_MOVE;
                    end
                end
                ST_MOVE: begin
                    if (center && own_piece) begin
                        selected <= cursor; // re-select, stay here
                    end else if (do_move) begin
                        wr_en <= 1'b1;
                        state <= ST_WRITE;
                    end
                end
                ST_WRITE: state <= ST_ERASE; // enable held for the erase
                ST_ERASE: begin
                    wr_en        <= 1'b0;
                    hilite       <= 1'b0;
                    side_to_move <= (side_to_move == piece_pkg::COLOR_WHITE) ?
                                    piece_pkg::COLOR_BLACK : piece_pkg::COLOR_WHITE;
                    state        <= ST_SELECT;
                end
                default: state <= ST_SELECT;
            endcase
        end
    end

    // write payload, target first then origin
    always_ff @(posedge CLK) begin
        if (do_move) begin
            wr_addr  <= cursor;
            wr_value <= sel_sq;
        end else if (state == ST_WRITE) begin
            wr_addr  <= selected;
            wr_value <= piece_pkg::EMPTY_SQUARE;
        end
    end

    assign wr = {wr_en, wr_addr, wr_value};

endmodule

`default_nettype wire

// ==== game/move_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module move_checker (
    input  wire board_pkg::board_t board,
    input  wire board_pkg::coord_t selected,
    input  wire board_pkg::coord_t cursor,
    input  wire piece_pkg::color_t side_to_move,
    output logic                   legal
);

    piece_pkg::square_t sel_sq;
    piece_pkg::square_t tgt_sq;
    piece_pkg::square_t mid_sq;
    logic signed [3:0]  d_row;
    logic signed [3:0]  d_col;
    logic signed [3:0]  fwd;
    logic signed [3:0]  fwd2;
    logic [3:0]         abs_row;
    logic [3:0]         abs_col;
    logic [2:0]         home_row;
    logic [2:0]         mid_row;
    logic               white;
    logic               tgt_empty;
    logic               opp_target;
    logic               own_target;
    logic               zero_move;
    logic               geom_ok;

    assign sel_sq = board[{selected.row, selected.col}];
    assign tgt_sq = board[{cursor.row, cursor.col}];

    // + means down the board / towards the h-file
    assign d_row   = $signed({1'b0, cursor.row}) - $signed({1'b0, selected.row});
    assign d_col   = $signed({1'b0, cursor.col}) - $signed({1'b0, selected.col});
    assign abs_row = d_row[3] ? -d_row : d_row;
    assign abs_col = d_col[3] ? -d_col : d_col;

    assign white    = (side_to_move == piece_pkg::COLOR_WHITE);
    assign fwd      = white ? -4'sd1 : 4'sd1; // white walks towards row 0
    assign fwd2     = white ? -4'sd2 : 4'sd2;
    assign home_row = white ? board_pkg::WHITE_PAWN_ROW : board_pkg::BLACK_PAWN_ROW;
    assign mid_row  = white ? selected.row - 3'd1 : selected.row + 3'd1;
    assign mid_sq   = board[{mid_row, selected.col}]; // square a double step passes

    assign tgt_empty  = (tgt_sq.kind == piece_pkg::PIECE_NONE);
    assign opp_target = !tgt_empty && (tgt_sq.color != side_to_move);
    assign own_target = !tgt_empty && (tgt_sq.color == side_to_move);
    assign zero_move  = (d_row == 4'sd0) && (d_col == 4'sd0);

    ////////////////////////////////////////////////////////////////////////////
    // per-kind geometry, paths of sliders are not checked

    always_comb begin
        case (sel_sq.kind)
            piece_pkg::PIECE_PAWN: begin
                geom_ok = (d_col == 4'sd0 && d_row == fwd && tgt_empty)
                       || (d_col == 4'sd0 && d_row == fwd2 && tgt_empty
                           && selected.row == home_row
                           && mid_sq.kind == piece_pkg::PIECE_NONE)
                       || (abs_col == 4'd1 && d_row == fwd && opp_target); // capture
            end
            piece_pkg::PIECE_KNIGHT: begin
                geom_ok = (abs_row == 4'd2 && abs_col == 4'd1)
                       || (abs_row == 4'd1 && abs_col == 4'd2);
            end
            piece_pkg::PIECE_BISHOP: geom_ok = (abs_row == abs_col);
            piece_pkg::PIECE_ROOK:   geom_ok = (d_row == 4'sd0) || (d_col == 4'sd0);
            piece_pkg::PIECE_QUEEN: begin
                geom_ok = (abs_row == abs_col) || (d_row == 4'sd0) || (d_col == 4'sd0);
            end
            piece_pkg::PIECE_KING: geom_ok = (abs_row <= 4'd1) && (abs_col <= 4'd1);
            default:               geom_ok = 1'b0; // nothing selected
        endcase
    end

    assign legal = geom_ok && !zero_move && !own_target;

endmodule

`default_nettype wire

// ==== hdl/cursor_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module cursor_ctrl (
    input  wire               CLK,
    input  wire               RESET,
    input  wire board_pkg::btn_t buttons,
    output board_pkg::coord_t cursor
);

    // one step per pulse, edges clamp
    always_ff @(posedge CLK or posedge RESET) begin
        if (RESET) begin
            cursor <= board_pkg::CURSOR_START;
        end else if (buttons.left) begin
            if (cursor.col != 3'd0) begin
                cursor.col <= cursor.col - 3'd1;
            end
        end else if (buttons.right) begin
            if (cursor.col != 3'd7) begin
                cursor.col <= cursor.col + 3'd1;
            end
        end else if (buttons.up) begin
            if (cursor.row != 3'd0) begin // up is towards black
                cursor.row <= cursor.row - 3'd1;
            end
        end else if (buttons.down) begin
            if (cursor.row != 3'd7) begin
                cursor.row <= cursor.row + 3'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== common/board_pkg.sv ====
`default_nettype none

package board_pkg;

    localparam int BOARD_DIM   = 8;
    localparam int NUM_SQUARES = 64;

    // row 0 is black's back rank, col 0 the a-file
    typedef struct packed {
        logic [2:0] row;
        logic [2:0] col;
    } coord_t;

    typedef piece_pkg::square_t [NUM_SQUARES-1:0] board_t; // index row*8 + col
    typedef piece_pkg::square_t [BOARD_DIM-1:0]   rank_t;

    typedef struct packed {
        logic left;
        logic right;
        logic up;
        logic down;
        logic center;
    } btn_t;

    typedef struct packed {
        logic               en;
        coord_t             addr;
        piece_pkg::square_t value;
    } board_wr_t;

    localparam logic [2:0] WHITE_PAWN_ROW = 3'd6;
    localparam logic [2:0] BLACK_PAWN_ROW = 3'd1;

    localparam coord_t CURSOR_START = '{row: 3'd6, col: 3'd4}; // e2

    ////////////////////////////////////////////////////////////////////////////
    // opening position

    // h-file first, a-file lands at index 0
    localparam piece_pkg::piece_kind_t [BOARD_DIM-1:0] BACK_KINDS = {
        piece_pkg::PIECE_ROOK,   piece_pkg::PIECE_KNIGHT, piece_pkg::PIECE_BISHOP,
        piece_pkg::PIECE_KING,   piece_pkg::PIECE_QUEEN,  piece_pkg::PIECE_BISHOP,
        piece_pkg::PIECE_KNIGHT, piece_pkg::PIECE_ROOK
    };

    function automatic rank_t fill_rank(piece_pkg::color_t side, logic back_rank);
        rank_t r;
        for (int i = 0; i < BOARD_DIM; i++) begin
            r[i].color = side;
            r[i].kind  = back_rank ? BACK_KINDS[i] : piece_pkg::PIECE_PAWN;
        end
        return r;
    endfunction

    // concatenation runs from row 7 down to row 0
    localparam board_t START_POSITION = {
        fill_rank(piece_pkg::COLOR_WHITE, 1'b1),
        fill_rank(piece_pkg::COLOR_WHITE, 1'b0),
        {(4*BOARD_DIM){piece_pkg::EMPTY_SQUARE}},
        fill_rank(piece_pkg::COLOR_BLACK, 1'b0),
        fill_rank(piece_pkg::COLOR_BLACK, 1'b1)
    };

endpackage

`default_nettype wire

// ==== common/piece_pkg.sv ====
`default_nettype none

package piece_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // piece kinds and colours

    typedef enum logic [2:0] {
        PIECE_NONE   = 3'd0,
        PIECE_PAWN   = 3'd1,
        PIECE_KNIGHT = 3'd2,
        PIECE_BISHOP = 3'd3,
        PIECE_ROOK   = 3'd4,
        PIECE_QUEEN  = 3'd5,
        PIECE_KING   = 3'd6
    } piece_kind_t;

    typedef enum logic {
        COLOR_WHITE = 1'b0,
        COLOR_BLACK = 1'b1
    } color_t;

    // one square of the board, colour in the msb
    typedef struct packed {
        color_t      color;
        piece_kind_t kind;
    } square_t;

    localparam square_t EMPTY_SQUARE = '{color: COLOR_WHITE, kind: PIECE_NONE};

endpackage

`default_nettype wire
